// ==== cache_stim.txt ====
// columns: op addr wmask wdata exp_rdata exp_miss exp_wb
// op 0 read, 1 write, 2 reset; exp_rdata only checked on reads
// cold read misses, same line then hits
0 00000040 0 00000000 5a5a5a4a 1 0
0 0000004c 0 00000000 5a5a5a49 0 0
// partial store hit, read back the merged word
1 00000048 3 deadbeef 00000000 0 0
0 00000048 0 00000000 5a5abeef 0 0
// four tags fill set 5
0 000000a0 0 00000000 5a5a5a72 1 0
0 000002a0 0 00000000 5a5a5af2 1 0
0 000004a0 0 00000000 5a5a5b72 1 0
0 000006a0 0 00000000 5a5a5bf2 1 0
// touch 0a0 then 4a0, victim is the way of 2a0
0 000000a0 0 00000000 5a5a5a72 0 0
0 000004a0 0 00000000 5a5a5b72 0 0
0 000008a0 0 00000000 5a5a5872 1 0
// survivors still hit
0 000000a0 0 00000000 5a5a5a72 0 0
0 000004a0 0 00000000 5a5a5b72 0 0
0 000006a0 0 00000000 5a5a5bf2 0 0
0 000008a0 0 00000000 5a5a5872 0 0
// evicted line misses again
0 000002a0 0 00000000 5a5a5af2 1 0
// dirty line in set 7, then four more tags push it out
1 000000e0 f 12345678 00000000 1 0
0 000002e0 0 00000000 5a5a5ae2 1 0
0 000004e0 0 00000000 5a5a5b62 1 0
0 000006e0 0 00000000 5a5a5be2 1 0
0 000008e0 0 00000000 5a5a5862 1 1
// stored word comes back from memory
0 000000e0 0 00000000 12345678 1 0
// reset mid-run drops every line
2 00000000 0 00000000 00000000 0 0
0 00000040 0 00000000 5a5a5a4a 1 0
0 00000044 0 00000000 5a5a5a4b 0 0

// ==== verilog.f ====
cache_pkg.sv
set_array.sv
cache_ways.sv
plru_tracker.sv
cache_ctrl.sv
cache_top.sv
cache_assertions.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_cache
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

    // seven words per stimulus record
    localparam int rec_words = 7;
    localparam int max_recs = 64;
    localparam int cycles_per_rec = 40;

    logic                         clk = 1'b0;
    logic                         rst;
    logic [cache_pkg::addr_w-1:0] ufp_addr;
    logic [cache_pkg::mask_w-1:0] ufp_rmask;
    logic [cache_pkg::mask_w-1:0] ufp_wmask;
    logic [cache_pkg::word_w-1:0] ufp_wdata;
    logic [cache_pkg::word_w-1:0] ufp_rdata;
    logic                         ufp_resp;
    logic [cache_pkg::addr_w-1:0] dfp_addr;
    logic                         dfp_read;
    logic                         dfp_write;
    cache_pkg::line_t             dfp_wdata;
    cache_pkg::line_t             dfp_rdata = '0;
    logic                         dfp_resp = 1'b0;

    logic [31:0] stim_mem [rec_words * max_recs];
    int          num_recs = 0;
    int          watchdog_cycles = 0;
    int          checks = 0;
    int          errors = 0;

    // sparse memory, keyed by line address
    cache_pkg::line_t mem_lines [logic [26:0]];
    logic [31:0]      lfsr = 32'he6e1_4712;
    logic [2:0]       draw;
    logic [3:0]       mem_wait;
    logic             mem_busy;

    cache_top uut (
        .clk      (clk),
        .rst      (rst),
        .ufp_addr (ufp_addr),
        .ufp_rmask(ufp_rmask),
        .ufp_wmask(ufp_wmask),
        .ufp_wdata(ufp_wdata),
        .ufp_rdata(ufp_rdata),
        .ufp_resp (ufp_resp),
        .dfp_addr (dfp_addr),
        .dfp_read (dfp_read),
        .dfp_write(dfp_write),
        .dfp_wdata(dfp_wdata),
        .dfp_rdata(dfp_rdata),
        .dfp_resp (dfp_resp)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // unwritten words read as their word address xor 5a5a5a5a
    function automatic cache_pkg::line_t line_from_memory(input logic [31:0] addr);
        cache_pkg::line_t fill;
        logic [31:0]      word_addr;
        if (mem_lines.exists(addr[31:5])) begin
            return mem_lines[addr[31:5]];
        end
        for (int i = 0; i < 8; i++) begin
            word_addr = {2'b00, addr[31:5], i[2:0]};
            fill[i * 32 +: 32] = word_addr ^ 32'h5a5a_5a5a;
        end
        return fill;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            dfp_resp <= 1'b0;
            mem_busy <= 1'b0;
            mem_wait <= '0;
        end else if (dfp_resp) begin
            dfp_resp <= 1'b0;
            mem_busy <= 1'b0;
        end else if (!mem_busy && (dfp_read || dfp_write)) begin
            // wait of 1 to 8 cycles
            for (int b = 0; b < 3; b++) begin
                lfsr = lfsr_next(lfsr);
                draw = {draw[1:0], lfsr[0]};
            end
            mem_busy <= 1'b1;
            mem_wait <= {1'b0, draw} + 4'd1;
        end else if (mem_busy) begin
            if (mem_wait == 4'd1) begin
                dfp_resp <= 1'b1;
                if (dfp_write) begin
                    mem_lines[dfp_addr[31:5]] = dfp_wdata;
                end else begin
                    dfp_rdata <= line_from_memory(dfp_addr);
                end
            end else begin
                mem_wait <= mem_wait - 4'd1;
            end
        end
    end

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_request(input int rec);
        int          base;
        int          cycles;
        logic [31:0] addr;
        logic        saw_read;
        logic        saw_write;
        logic        got_resp;
        logic [31:0] rdata;
        logic [31:0] read_addr;
        logic [31:0] write_addr;
        base = rec * rec_words;
        addr = stim_mem[base + 1];
        cycles = 0;
        saw_read = 1'b0;
        saw_write = 1'b0;
        got_resp = 1'b0;
        rdata = '0;
        read_addr = '0;
        write_addr = '0;
        @(posedge clk);
        ufp_addr <= addr;
        if (stim_mem[base] == 32'd1) begin
            ufp_wmask <= stim_mem[base + 2][3:0];
            ufp_wdata <= stim_mem[base + 3];
        end else begin
            ufp_rmask <= 4'hf;
        end
        // memory traffic seen while the request is held
        while (!got_resp) begin
            @(negedge clk);
            cycles++;
            if (dfp_read) begin
                saw_read = 1'b1;
                read_addr = dfp_addr;
            end
            if (dfp_write) begin
                saw_write = 1'b1;
                write_addr = dfp_addr;
            end
            if (ufp_resp) begin
                got_resp = 1'b1;
                rdata = ufp_rdata;
            end
        end
        @(posedge clk);
        ufp_rmask <= '0;
        ufp_wmask <= '0;
        checks++;
        if (saw_read != stim_mem[base + 5][0]) begin
            $display("FAILED dfp_read at addr %h: got %h expected %h",
                     addr, saw_read, stim_mem[base + 5][0]);
            errors++;
        end
        if (saw_write != stim_mem[base + 6][0]) begin
            $display("FAILED dfp_write at addr %h: got %h expected %h",
                     addr, saw_write, stim_mem[base + 6][0]);
            errors++;
        end
        // refill fetches the requested line
        if (saw_read && (read_addr != {addr[31:5], 5'b0})) begin
            $display("FAILED dfp_addr on refill at addr %h: got %h expected %h",
                     addr, read_addr, {addr[31:5], 5'b0});
            errors++;
        end
        // victim line sits in the same set
        if (saw_write && (write_addr[8:0] != {addr[8:5], 5'b0})) begin
            $display("FAILED dfp_addr on write-back at addr %h: got low bits %h expected %h",
                     addr, write_addr[8:0], {addr[8:5], 5'b0});
            errors++;
        end
        // a hit answers in the cycle after the first request cycle
        if (!stim_mem[base + 5][0] && (cycles != 2)) begin
            $display("hit at addr %h was answered %0d cycles after the request instead of 1",
                     addr, cycles - 1);
            errors++;
        end
        if ((stim_mem[base] == 32'd0) && (rdata != stim_mem[base + 4])) begin
            $display("FAILED ufp_rdata at addr %h: got %h expected %h",
                     addr, rdata, stim_mem[base + 4]);
            errors++;
        end
    endtask

    initial begin
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        for (int i = 0; i < rec_words * max_recs; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("cache_stim.txt", stim_mem);
        while ((num_recs < max_recs) && (stim_mem[num_recs * rec_words] != 32'hffff_ffff)) begin
            num_recs++;
        end
        watchdog_cycles = (num_recs + 1) * cycles_per_rec;
        if (num_recs == 0) begin
            $display("stimulus file holds no records");
            errors++;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < num_recs; r++) begin
            case (stim_mem[r * rec_words])
                32'd0, 32'd1: run_request(r);
                32'd2: reset_dut();
                default: begin
                    $display("stimulus record %0d has an unknown operation", r);
                    errors++;
                end
            endcase
        end
        $display("records: %0d, checks: %0d, errors: %0d", num_recs, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a request got no response",
                 watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== cache_assertions.sv ====
`timescale 1ns/1ps

module cache_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic [cache_pkg::mask_w-1:0] ufp_rmask,
    input logic [cache_pkg::mask_w-1:0] ufp_wmask,
    input logic                         ufp_resp,
    input logic [cache_pkg::addr_w-1:0] dfp_addr,
    input logic                         dfp_read,
    input logic                         dfp_write,
    input logic                         dfp_resp
);

    // one memory direction at a time
    assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    // request and address held until memory answers
    assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> (dfp_read && $stable(dfp_addr)))
        else $error("dfp_read or dfp_addr changed before dfp_resp");

    assert property (@(posedge clk) disable iff (rst)
        (dfp_write && !dfp_resp) |=> (dfp_write && $stable(dfp_addr)))
        else $error("dfp_write or dfp_addr changed before dfp_resp");

    assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> ((ufp_rmask != '0) || (ufp_wmask != '0)))
        else $error("ufp_resp without a pending request");

    assert property (@(posedge clk) (rst && $past(rst)) |-> !(dfp_read || dfp_write))
        else $error("memory request during reset");

endmodule

bind cache_top cache_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .ufp_rmask(ufp_rmask),
    .ufp_wmask(ufp_wmask),
    .ufp_resp (ufp_resp),
    .dfp_addr (dfp_addr),
    .dfp_read (dfp_read),
    .dfp_write(dfp_write),
    .dfp_resp (dfp_resp)
);

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cache_pkg::addr_w-1:0] ufp_addr,
    input  logic [cache_pkg::mask_w-1:0] ufp_rmask,
    input  logic [cache_pkg::mask_w-1:0] ufp_wmask,
    input  logic [cache_pkg::word_w-1:0] ufp_wdata,
    output logic [cache_pkg::word_w-1:0] ufp_rdata,
    output logic                         ufp_resp,
    output logic [cache_pkg::addr_w-1:0] dfp_addr,
    output logic                         dfp_read,
    output logic                         dfp_write,
    output cache_pkg::line_t             dfp_wdata,
    input  cache_pkg::line_t             dfp_rdata,
    input  logic                         dfp_resp
);

    // lookup results
    logic                           hit;
    logic [cache_pkg::way_w-1:0]    hit_way;
    cache_pkg::line_t               hit_line;
    cache_pkg::tag_entry_t          sel_entry;
    cache_pkg::line_t               sel_line;
    logic [cache_pkg::num_ways-1:0] valid_vec;

    // array control from the FSM
    logic [cache_pkg::set_w-1:0] rd_set;
    logic [cache_pkg::tag_w-1:0] req_tag;
    logic [cache_pkg::way_w-1:0] sel_way;
    logic [cache_pkg::way_w-1:0] wr_way;
    logic [cache_pkg::set_w-1:0] wr_set;
    logic                        wr_tag_en;
    logic                        wr_line_en;
    cache_pkg::tag_entry_t       wr_entry;
    cache_pkg::line_t            wr_line;
    logic                        set_valid;

    // replacement
    logic                        touch;
    logic [cache_pkg::way_w-1:0] touch_way;
    logic [cache_pkg::way_w-1:0] victim_way;

    cache_ways u_ways (
        .clk       (clk),
        .rst       (rst),
        .rd_set    (rd_set),
        .req_tag   (req_tag),
        .sel_way   (sel_way),
        .wr_way    (wr_way),
        .wr_set    (wr_set),
        .wr_tag_en (wr_tag_en),
        .wr_line_en(wr_line_en),
        .wr_entry  (wr_entry),
        .wr_line   (wr_line),
        .set_valid (set_valid),
        .hit       (hit),
        .hit_way   (hit_way),
        .hit_line  (hit_line),
        .sel_entry (sel_entry),
        .sel_line  (sel_line),
        .valid_vec (valid_vec)
    );

    // plru indexed by the held request's set
    plru_tracker u_plru (
        .clk       (clk),
        .rst       (rst),
        .set       (wr_set),
        .touch     (touch),
        .touch_way (touch_way),
        .victim_way(victim_way)
    );

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .hit       (hit),
        .hit_way   (hit_way),
        .hit_line  (hit_line),
        .sel_entry (sel_entry),
        .sel_line  (sel_line),
        .valid_vec (valid_vec),
        .victim_way(victim_way),
        .rd_set    (rd_set),
        .req_tag   (req_tag),
        .sel_way   (sel_way),
        .wr_way    (wr_way),
        .wr_set    (wr_set),
        .wr_tag_en (wr_tag_en),
        .wr_line_en(wr_line_en),
        .wr_entry  (wr_entry),
        .wr_line   (wr_line),
        .set_valid (set_valid),
        .touch     (touch),
        .touch_way (touch_way)
    );

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cache_pkg::addr_w-1:0]   ufp_addr,
    input  logic [cache_pkg::mask_w-1:0]   ufp_rmask,
    input  logic [cache_pkg::mask_w-1:0]   ufp_wmask,
    input  logic [cache_pkg::word_w-1:0]   ufp_wdata,
    output logic [cache_pkg::word_w-1:0]   ufp_rdata,
    output logic                           ufp_resp,
    output logic [cache_pkg::addr_w-1:0]   dfp_addr,
    output logic                           dfp_read,
    output logic                           dfp_write,
    output cache_pkg::line_t               dfp_wdata,
    input  cache_pkg::line_t               dfp_rdata,
    input  logic                           dfp_resp,
    input  logic                           hit,
    input  logic [cache_pkg::way_w-1:0]    hit_way,
    input  cache_pkg::line_t               hit_line,
    input  cache_pkg::tag_entry_t          sel_entry,
    input  cache_pkg::line_t               sel_line,
    input  logic [cache_pkg::num_ways-1:0] valid_vec,
    input  logic [cache_pkg::way_w-1:0]    victim_way,
    output logic [cache_pkg::set_w-1:0]    rd_set,
    output logic [cache_pkg::tag_w-1:0]    req_tag,
    output logic [cache_pkg::way_w-1:0]    sel_way,
    output logic [cache_pkg::way_w-1:0]    wr_way,
    output logic [cache_pkg::set_w-1:0]    wr_set,
    output logic                           wr_tag_en,
    output logic                           wr_line_en,
    output cache_pkg::tag_entry_t          wr_entry,
    output cache_pkg::line_t               wr_line,
    output logic                           set_valid,
    output logic                           touch,
    output logic [cache_pkg::way_w-1:0]    touch_way
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        install,
        reread
    } state_t;

    state_t state_q;
    state_t state_d;

    // held request
    logic [cache_pkg::addr_w-1:0]     req_addr;
    logic [cache_pkg::mask_w-1:0]     req_wmask;
    logic [cache_pkg::word_w-1:0]     req_wdata;
    logic [cache_pkg::set_w-1:0]      req_set;
    logic [cache_pkg::word_sel_w-1:0] req_word;

    logic [cache_pkg::way_w-1:0] fill_pick;
    logic [cache_pkg::way_w-1:0] fill_way_q;
    cache_pkg::line_t            refill_line;
    cache_pkg::line_t            merged_line;
    logic                        lookup_hit;

    assign req_set = req_addr[cache_pkg::set_lsb +: cache_pkg::set_w];
    assign req_word = req_addr[cache_pkg::word_lsb +: cache_pkg::word_sel_w];
    assign req_tag = req_addr[cache_pkg::tag_lsb +: cache_pkg::tag_w];

    // arrays follow the live address only while waiting for a request
    assign rd_set = (state_q == idle) ? ufp_addr[cache_pkg::set_lsb +: cache_pkg::set_w]
                                      : req_set;
    assign wr_set = req_set;

    // lowest invalid way first, plru victim when the set is full
    always_comb begin
        fill_pick = victim_way;
        for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                fill_pick = w[cache_pkg::way_w-1:0];
            end
        end
    end

    // byte merge of the store into the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < cache_pkg::mask_w; b++) begin
            if (req_wmask[b]) begin
                merged_line[req_word * cache_pkg::word_w + b * 8 +: 8] = req_wdata[b * 8 +: 8];
            end
        end
    end

    assign lookup_hit = (state_q == lookup) && hit;

    assign ufp_resp = lookup_hit;
    assign ufp_rdata = hit_line[req_word * cache_pkg::word_w +: cache_pkg::word_w];

    assign touch = lookup_hit;
    assign touch_way = hit_way;

    // hit store in lookup, clean fill in install
    assign sel_way = (state_q == lookup) ? fill_pick : fill_way_q;
    assign wr_way = (state_q == install) ? fill_way_q : hit_way;
    assign wr_tag_en = (lookup_hit && (req_wmask != '0)) || (state_q == install);
    assign wr_line_en = wr_tag_en;
    assign set_valid = (state_q == install);
    assign wr_entry.dirty = (state_q == lookup);
    assign wr_entry.tag = req_tag;
    assign wr_line = (state_q == install) ? refill_line : merged_line;

    // memory port, held stable for the whole handshake
    assign dfp_read = (state_q == refill);
    assign dfp_write = (state_q == write_back);
    assign dfp_wdata = sel_line;
    assign dfp_addr = (state_q == write_back)
        ? {sel_entry.tag, req_set, {cache_pkg::offset_w{1'b0}}}
        : {req_addr[cache_pkg::addr_w-1:cache_pkg::set_lsb], {cache_pkg::offset_w{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if ((ufp_rmask != '0) || (ufp_wmask != '0)) begin
                    state_d = lookup;
                end
            end
            lookup: begin
                if (hit) begin
                    state_d = idle;
                end else if (valid_vec[fill_pick] && sel_entry.dirty) begin
                    state_d = write_back;
                end else begin
                    state_d = refill;
                end
            end
            write_back: begin
                if (dfp_resp) begin
                    state_d = refill;
                end
            end
            refill: begin
                if (dfp_resp) begin
                    state_d = install;
                end
            end
            install: state_d = reread;
            reread: state_d = lookup;
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle) begin
            req_addr <= ufp_addr;
            req_wmask <= ufp_wmask;
            req_wdata <= ufp_wdata;
        end
        // fill way fixed once the miss is seen
        if (state_q == lookup) begin
            fill_way_q <= fill_pick;
        end
        if ((state_q == refill) && dfp_resp) begin
            refill_line <= dfp_rdata;
        end
    end

endmodule

// ==== plru_tracker.sv ====
`timescale 1ns/1ps

module plru_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [cache_pkg::set_w-1:0] set,
    input  logic                        touch,
    input  logic [cache_pkg::way_w-1:0] touch_way,
    output logic [cache_pkg::way_w-1:0] victim_way
);

    // bit 2: mru half, bit 1: mru of ways 0-1, bit 0: mru of ways 2-3
    logic [cache_pkg::plru_w-1:0] tree [cache_pkg::num_sets];
    logic [cache_pkg::plru_w-1:0] cur_tree;
    logic [cache_pkg::plru_w-1:0] next_tree;

    assign cur_tree = tree[set];

    // walk away from the recent side at each node
    always_comb begin
        if (cur_tree[2]) begin
            victim_way = {1'b0, ~cur_tree[1]};
        end else begin
            victim_way = {1'b1, ~cur_tree[0]};
        end
    end

    // point the nodes on the touched path at the touched way
    always_comb begin
        next_tree = cur_tree;
        next_tree[2] = touch_way[1];
        if (touch_way[1]) begin
            next_tree[0] = touch_way[0];
        end else begin
            next_tree[1] = touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set] <= next_tree;
        end
    end

endmodule

// ==== cache_ways.sv ====
`timescale 1ns/1ps

module cache_ways (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cache_pkg::set_w-1:0]   rd_set,
    input  logic [cache_pkg::tag_w-1:0]   req_tag,
    input  logic [cache_pkg::way_w-1:0]   sel_way,
    input  logic [cache_pkg::way_w-1:0]   wr_way,
    input  logic [cache_pkg::set_w-1:0]   wr_set,
    input  logic                          wr_tag_en,
    input  logic                          wr_line_en,
    input  cache_pkg::tag_entry_t         wr_entry,
    input  cache_pkg::line_t              wr_line,
    input  logic                          set_valid,
    output logic                          hit,
    output logic [cache_pkg::way_w-1:0]   hit_way,
    output cache_pkg::line_t              hit_line,
    output cache_pkg::tag_entry_t         sel_entry,
    output cache_pkg::line_t              sel_line,
    output logic [cache_pkg::num_ways-1:0] valid_vec
);

    cache_pkg::tag_entry_t tag_q [cache_pkg::num_ways];
    cache_pkg::line_t      line_q [cache_pkg::num_ways];

    // valid bits per set, one per way
    logic [cache_pkg::num_ways-1:0] valid_mem [cache_pkg::num_sets];

    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        set_array #(
            .entry_t(cache_pkg::tag_entry_t)
        ) u_tag (
            .clk    (clk),
            .rd_set (rd_set),
            .rd_data(tag_q[w]),
            .wr_en  (wr_tag_en && (wr_way == w)),
            .wr_set (wr_set),
            .wr_data(wr_entry)
        );

        set_array #(
            .entry_t(cache_pkg::line_t)
        ) u_line (
            .clk    (clk),
            .rd_set (rd_set),
            .rd_data(line_q[w]),
            .wr_en  (wr_line_en && (wr_way == w)),
            .wr_set (wr_set),
            .wr_data(wr_line)
        );
    end

    // read alongside the arrays so valid_vec lines up with tag_q
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid_mem[s] <= '0;
            end
            valid_vec <= '0;
        end else begin
            valid_vec <= valid_mem[rd_set];
            if (set_valid) begin
                valid_mem[wr_set][wr_way] <= 1'b1;
            end
        end
    end

    // scan downward so the lowest matching way wins
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
            if (valid_vec[w] && (tag_q[w].tag == req_tag)) begin
                hit = 1'b1;
                hit_way = w[cache_pkg::way_w-1:0];
            end
        end
    end

    assign hit_line = line_q[hit_way];

    // victim read-out for write-back
    assign sel_entry = tag_q[sel_way];
    assign sel_line = line_q[sel_way];

endmodule

// ==== set_array.sv ====
`timescale 1ns/1ps

module set_array #(
    parameter type entry_t = cache_pkg::line_t
) (
    input  logic                      clk,
    input  logic [cache_pkg::set_w-1:0] rd_set,
    output entry_t                    rd_data,
    input  logic                      wr_en,
    input  logic [cache_pkg::set_w-1:0] wr_set,
    input  entry_t                    wr_data
);

    // one entry per set
    entry_t mem [cache_pkg::num_sets];

    // registered read, same-set write returns the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_set] <= wr_data;
        end
        rd_data <= mem[rd_set];
    end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // address and data widths
    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int line_w = 256;
    localparam int mask_w = 4;

    // geometry
    localparam int num_ways = 4;
    localparam int way_w = 2;
    localparam int num_sets = 16;

    // address split: tag | set | word | byte
    localparam int offset_w = 5;
    localparam int set_w = 4;
    localparam int word_sel_w = 3;
    localparam int tag_w = 23;
    localparam int word_lsb = 2;
    localparam int set_lsb = offset_w;
    localparam int tag_lsb = offset_w + set_w;

    // tree plru, one bit per inner node
    localparam int plru_w = 3;

    // dirty bit sits above the tag
    typedef struct packed {
        logic             dirty;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    typedef logic [line_w-1:0] line_t;

endpackage
